// File: common/masked_ntt_pkg.sv
package masked_ntt_pkg;

    // dilithium prime and share width
    localparam int unsigned COEFF_W = 23;
    localparam logic [COEFF_W-1:0] Q = 23'd8380417;

    // floor(2^46 / Q), used for barrett reduction of a 46 bit product
    localparam logic [23:0] BARRETT_M = 24'((64'd1 << 46) / 64'(Q));

    // pipeline latencies in clock cycles
    localparam int unsigned ADD_SUB_LATENCY = 2;
    localparam int unsigned MULT_LATENCY = 3;
    localparam int unsigned BF_LATENCY = 6;

    // random generator: five right-shifting galois lfsrs
    localparam int unsigned PRNG_LANES = 5;
    localparam logic [31:0] PRNG_TAPS = 32'hA300_0000;
    localparam logic [PRNG_LANES-1:0][31:0] PRNG_SALT = {
        32'h1F3A_6C95, 32'hB7E1_5163, 32'h9E37_79B9, 32'h5A82_7999, 32'hC3D2_E1F0
    };

    // axi4-lite register map
    localparam int unsigned AXI_ADDR_W = 4;
    localparam int unsigned AXI_DATA_W = 32;
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_ZEROIZE = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_SEED = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_COUNT = 4'hC;
    localparam int unsigned CTRL_MODE_BIT = 0;
    localparam int unsigned CTRL_ACC_BIT = 1;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    typedef enum logic {
        gs  = 1'b0,
        pwm = 1'b1
    } mode_t;

    // the real value is (share0 + share1) mod Q
    typedef struct packed {
        logic [COEFF_W-1:0] share0;
        logic [COEFF_W-1:0] share1;
    } masked_coeff_t;

    typedef struct packed {
        masked_coeff_t opu;
        masked_coeff_t opv;
        masked_coeff_t opw;
    } bf_in_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
    } bf_out_t;

    // every word is already reduced below Q
    typedef struct packed {
        logic [COEFF_W-1:0] r0;
        logic [COEFF_W-1:0] r1;
        logic [COEFF_W-1:0] r2;
        logic [COEFF_W-1:0] r3;
        logic [COEFF_W-1:0] r4;
    } rnd_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_DATA_W/8-1:0] wstrb;
        logic                  wvalid;
        logic                  bready;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
        logic                  arready;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
    } axil_rsp_t;

    // folds a value below 2Q into [0, Q)
    function automatic logic [COEFF_W-1:0] cond_sub(input logic [COEFF_W:0] x);
        return (x >= {1'b0, Q}) ? COEFF_W'(x - {1'b0, Q}) : x[COEFF_W-1:0];
    endfunction

    function automatic logic [COEFF_W-1:0] add_mod(input logic [COEFF_W-1:0] a,
                                                   input logic [COEFF_W-1:0] b);
        return cond_sub({1'b0, a} + {1'b0, b});
    endfunction

    function automatic logic [COEFF_W-1:0] sub_mod(input logic [COEFF_W-1:0] a,
                                                   input logic [COEFF_W-1:0] b);
        logic [COEFF_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        // borrow means a < b, so wrap back by adding Q
        return d[COEFF_W] ? COEFF_W'(d + {1'b0, Q}) : d[COEFF_W-1:0];
    endfunction

    // barrett reduction, the quotient estimate is at most one low so r < 2Q
    function automatic logic [COEFF_W-1:0] mul_mod(input logic [COEFF_W-1:0] a,
                                                   input logic [COEFF_W-1:0] b);
        logic [2*COEFF_W-1:0]  x;
        logic [2*COEFF_W+23:0] t;
        logic [23:0]           qhat;
        logic [2*COEFF_W+1:0]  r;
        x = a * b;
        t = x * BARRETT_M;
        qhat = t[2*COEFF_W+23:2*COEFF_W];
        r = {2'b00, x} - qhat * Q;
        return cond_sub(r[COEFF_W:0]);
    endfunction

endpackage

// File: rtl/share_delay.sv
`timescale 1ns/100ps

module share_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     zeroize_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t pipe_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign q_o = pipe_q[DEPTH-1];

endmodule

// File: rtl/masked_add_sub.sv
`timescale 1ns/100ps

module masked_add_sub
    import masked_ntt_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               sub_i,
    input  masked_coeff_t      u_i,
    input  masked_coeff_t      v_i,
    input  logic [COEFF_W-1:0] rnd_i,
    output masked_coeff_t      res_o
);

    masked_coeff_t sum_q;

    // stage one works share by share, the two shares never meet
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q <= '0;
        end else if (zeroize_i) begin
            sum_q <= '0;
        end else if (sub_i) begin
            sum_q.share0 <= sub_mod(u_i.share0, v_i.share0);
            sum_q.share1 <= sub_mod(u_i.share1, v_i.share1);
        end else begin
            sum_q.share0 <= add_mod(u_i.share0, v_i.share0);
            sum_q.share1 <= add_mod(u_i.share1, v_i.share1);
        end
    end

    // stage two moves rnd from one share to the other, the sum is unchanged
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o.share0 <= add_mod(sum_q.share0, rnd_i);
            res_o.share1 <= sub_mod(sum_q.share1, rnd_i);
        end
    end

endmodule

// File: rtl/masked_mult.sv
`timescale 1ns/100ps

module masked_mult
    import masked_ntt_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  masked_coeff_t      u_i,
    input  masked_coeff_t      v_i,
    input  logic [COEFF_W-1:0] rnd_a_i,
    input  logic [COEFF_W-1:0] rnd_b_i,
    output masked_coeff_t      res_o
);

    logic [COEFF_W-1:0] p00_q;
    logic [COEFF_W-1:0] p01_q;
    logic [COEFF_W-1:0] p10_q;
    logic [COEFF_W-1:0] p11_q;
    masked_coeff_t      mix_q;

    // stage one: all four partial products, reduced mod Q
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
        end else if (zeroize_i) begin
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
        end else begin
            p00_q <= mul_mod(u_i.share0, v_i.share0);
            p01_q <= mul_mod(u_i.share0, v_i.share1);
            p10_q <= mul_mod(u_i.share1, v_i.share0);
            p11_q <= mul_mod(u_i.share1, v_i.share1);
        end
    end

    // stage two: each domain keeps its own product plus one cross term,
    // rnd_a hides the cross terms before they are combined
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mix_q <= '0;
        end else if (zeroize_i) begin
            mix_q <= '0;
        end else begin
            mix_q.share0 <= add_mod(add_mod(p00_q, p01_q), rnd_a_i);
            mix_q.share1 <= sub_mod(add_mod(p11_q, p10_q), rnd_a_i);
        end
    end

    // stage three: final refresh
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o.share0 <= add_mod(mix_q.share0, rnd_b_i);
            res_o.share1 <= sub_mod(mix_q.share1, rnd_b_i);
        end
    end

endmodule

// File: rtl/mask_prng.sv
`timescale 1ns/100ps

module mask_prng
    import masked_ntt_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] seed_i,
    input  logic        seed_load_i,
    output rnd_t        rnd_o
);

    logic [31:0]        lfsr_q [PRNG_LANES];
    logic [COEFF_W-1:0] word [PRNG_LANES];

    // reset state equals a load of seed zero
    // bit 0 is forced so no lane can start in the all-zero lock-up state
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < PRNG_LANES; i++) begin
                lfsr_q[i] <= PRNG_SALT[i] | 32'h1;
            end
        end else if (seed_load_i) begin
            for (int i = 0; i < PRNG_LANES; i++) begin
                lfsr_q[i] <= (seed_i ^ PRNG_SALT[i]) | 32'h1;
            end
        end else begin
            for (int i = 0; i < PRNG_LANES; i++) begin
                lfsr_q[i] <= {1'b0, lfsr_q[i][31:1]} ^ (lfsr_q[i][0] ? PRNG_TAPS : 32'h0);
            end
        end
    end

    // upper bits are below 2^23 < 2Q, one subtraction folds them below Q
    always_comb begin
        for (int i = 0; i < PRNG_LANES; i++) begin
            word[i] = cond_sub({1'b0, lfsr_q[i][31:32-COEFF_W]});
        end
    end

    assign rnd_o.r0 = word[0];
    assign rnd_o.r1 = word[1];
    assign rnd_o.r2 = word[2];
    assign rnd_o.r3 = word[3];
    assign rnd_o.r4 = word[4];

endmodule

// File: masked_butterfly/masked_gs_butterfly.sv
`timescale 1ns/100ps

module masked_gs_butterfly
    import masked_ntt_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    zeroize_i,
    input  mode_t   mode_i,
    input  logic    accumulate_i,
    input  bf_in_t  bf_i,
    input  rnd_t    rnd_i,
    output bf_out_t bf_o
);

    logic               pwm_mode;
    logic               pwm_acc;
    logic [COEFF_W-1:0] add_rnd;
    masked_coeff_t      add_u;
    masked_coeff_t      add_v;
    masked_coeff_t      add_res;
    masked_coeff_t      sub_res;
    masked_coeff_t      sum_d;
    masked_coeff_t      w_gs_d;
    masked_coeff_t      w_pwm_d;
    masked_coeff_t      mul_u;
    masked_coeff_t      mul_v;
    masked_coeff_t      mul_res;
    masked_coeff_t      prod_q;
    masked_coeff_t      prod_d;
    masked_coeff_t      u_q;

    assign pwm_mode = (mode_i == pwm);
    assign pwm_acc  = pwm_mode & accumulate_i;

    // gs: u+v, pwm with accumulate: u*v + w
    assign add_u   = pwm_acc ? prod_q : bf_i.opu;
    assign add_v   = pwm_acc ? w_pwm_d : bf_i.opv;
    assign add_rnd = pwm_acc ? rnd_i.r4 : rnd_i.r0;

    masked_add_sub u_add (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .u_i       (add_u),
        .v_i       (add_v),
        .rnd_i     (add_rnd),
        .res_o     (add_res)
    );

    masked_add_sub u_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .u_i       (bf_i.opu),
        .v_i       (bf_i.opv),
        .rnd_i     (rnd_i.r1),
        .res_o     (sub_res)
    );

    // sum waits for the product side, one more cycle in u_q
    share_delay #(.payload_t(masked_coeff_t), .DEPTH(BF_LATENCY - ADD_SUB_LATENCY - 1)) u_sum_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (add_res),
        .q_o       (sum_d)
    );

    // w meets u-v at the multiplier input
    share_delay #(.payload_t(masked_coeff_t), .DEPTH(ADD_SUB_LATENCY)) u_w_gs_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (bf_i.opw),
        .q_o       (w_gs_d)
    );

    // w meets the registered product at the adder input in pwm mode
    share_delay #(.payload_t(masked_coeff_t), .DEPTH(MULT_LATENCY + 1)) u_w_pwm_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (bf_i.opw),
        .q_o       (w_pwm_d)
    );

    assign mul_u = pwm_mode ? bf_i.opu : sub_res;
    assign mul_v = pwm_mode ? bf_i.opv : w_gs_d;

    masked_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .u_i       (mul_u),
        .v_i       (mul_v),
        .rnd_a_i   (rnd_i.r2),
        .rnd_b_i   (rnd_i.r3),
        .res_o     (mul_res)
    );

    // without accumulate the product just covers the adder's two cycles
    share_delay #(.payload_t(masked_coeff_t), .DEPTH(BF_LATENCY - MULT_LATENCY - 1)) u_prod_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (prod_q),
        .q_o       (prod_d)
    );

    // prod_q is the gs v output and the pwm product register at once
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            u_q    <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            u_q    <= '0;
        end else begin
            prod_q <= mul_res;
            u_q    <= sum_d;
        end
    end

    always_comb begin
        if (pwm_mode) begin
            bf_o.u = accumulate_i ? add_res : prod_d;
            bf_o.v = '0;
        end else begin
            bf_o.u = u_q;
            bf_o.v = prod_q;
        end
    end

endmodule

// File: masked_butterfly/bf_ctrl_regs.sv
`timescale 1ns/100ps

module bf_ctrl_regs
    import masked_ntt_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  axil_req_t   axil_req_i,
    output axil_rsp_t   axil_rsp_o,
    input  logic        bf_done_i,
    output mode_t       mode_o,
    output logic        accumulate_o,
    output logic        zeroize_o,
    output logic [31:0] seed_o,
    output logic        seed_load_o
);

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_mapped;
    mode_t                 mode_q;
    logic                  acc_q;
    logic                  zeroize_q;
    logic [31:0]           seed_q;
    logic                  seed_load_q;
    logic [31:0]           count_q;
    logic [AXI_DATA_W-1:0] ctrl_word;
    logic                  bvalid_q;
    logic [1:0]            bresp_q;
    logic                  rvalid_q;
    logic [1:0]            rresp_q;
    logic [AXI_DATA_W-1:0] rdata_q;

    // a write needs both aw and w, and no response may be pending
    assign wr_fire   = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
    assign rd_fire   = axil_req_i.arvalid & ~rvalid_q;
    assign wr_mapped = axil_req_i.awaddr inside {REG_CTRL, REG_ZEROIZE, REG_SEED, REG_COUNT};

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_MODE_BIT] = (mode_q == pwm);
        ctrl_word[CTRL_ACC_BIT]  = acc_q;
    end

    // register writes, zeroize and seed load are single-cycle pulses
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q      <= gs;
            acc_q       <= 1'b0;
            zeroize_q   <= 1'b0;
            seed_q      <= '0;
            seed_load_q <= 1'b0;
        end else begin
            zeroize_q   <= 1'b0;
            seed_load_q <= 1'b0;
            if (zeroize_q) begin
                mode_q <= gs;
                acc_q  <= 1'b0;
            end else if (wr_fire) begin
                case (axil_req_i.awaddr)
                    REG_CTRL: begin
                        if (axil_req_i.wstrb[0]) begin
                            mode_q <= mode_t'(axil_req_i.wdata[CTRL_MODE_BIT]);
                            acc_q  <= axil_req_i.wdata[CTRL_ACC_BIT];
                        end
                    end
                    REG_ZEROIZE: zeroize_q <= axil_req_i.wstrb[0] & axil_req_i.wdata[0];
                    REG_SEED: begin
                        for (int b = 0; b < 4; b++) begin
                            if (axil_req_i.wstrb[b]) begin
                                seed_q[8*b +: 8] <= axil_req_i.wdata[8*b +: 8];
                            end
                        end
                        seed_load_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // finished butterflies since reset or the last zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (zeroize_q) begin
            count_q <= '0;
        end else if (bf_done_i) begin
            count_q <= count_q + 32'd1;
        end
    end

    // write response, count is read only so writes to it are dropped quietly
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= AXI_RESP_OKAY;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end else if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid_q <= 1'b0;
            rresp_q  <= AXI_RESP_OKAY;
            rdata_q  <= '0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rresp_q  <= AXI_RESP_OKAY;
            case (axil_req_i.araddr)
                REG_CTRL:    rdata_q <= ctrl_word;
                REG_ZEROIZE: rdata_q <= '0;
                REG_SEED:    rdata_q <= seed_q;
                REG_COUNT:   rdata_q <= count_q;
                default: begin
                    rdata_q <= '0;
                    rresp_q <= AXI_RESP_SLVERR;
                end
            endcase
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = ~rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.rvalid  = rvalid_q;
    end

    assign mode_o       = mode_q;
    assign accumulate_o = acc_q;
    assign zeroize_o    = zeroize_q;
    assign seed_o       = seed_q;
    assign seed_load_o  = seed_load_q;

endmodule

// File: rtl/masked_bf_top.sv
`timescale 1ns/100ps

module masked_bf_top
    import masked_ntt_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    input  logic      in_valid_i,
    input  bf_in_t    bf_in_i,
    output logic      out_valid_o,
    output bf_out_t   bf_out_o
);

    mode_t       mode;
    logic        accumulate;
    logic        zeroize;
    logic [31:0] seed;
    logic        seed_load;
    rnd_t        rnd;
    logic        out_valid;

    bf_ctrl_regs u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .axil_req_i   (axil_req_i),
        .axil_rsp_o   (axil_rsp_o),
        .bf_done_i    (out_valid),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .zeroize_o    (zeroize),
        .seed_o       (seed),
        .seed_load_o  (seed_load)
    );

    mask_prng u_prng (
        .clk         (clk),
        .reset_n     (reset_n),
        .seed_i      (seed),
        .seed_load_i (seed_load),
        .rnd_o       (rnd)
    );

    masked_gs_butterfly u_bf (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .bf_i         (bf_in_i),
        .rnd_i        (rnd),
        .bf_o         (bf_out_o)
    );

    // valid runs beside the datapath with the same fixed latency
    share_delay #(.payload_t(logic), .DEPTH(BF_LATENCY)) u_valid_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .d_i       (in_valid_i),
        .q_o       (out_valid)
    );

    assign out_valid_o = out_valid;

endmodule

// File: verif/tb_masked_bf.sv
`timescale 1ns/100ps

module tb_masked_bf
    import masked_ntt_pkg::*;
();

    localparam int HANDSHAKE_LIMIT = 20;
    localparam int DRAIN_LIMIT = 50;

    logic          clk;
    logic          reset_n;
    axil_req_t     axil_req;
    axil_rsp_t     axil_rsp;
    logic          in_valid_i;
    bf_in_t        bf_in_i;
    logic          out_valid_o;
    bf_out_t       bf_out_o;

    integer        seed;
    mode_t         model_mode;
    logic          model_acc;
    longint        exp_u_q[$];
    longint        exp_v_q[$];
    longint        in_time_q[$];
    longint        cycle;
    int            in_sent;
    masked_coeff_t last_u;

    masked_bf_top dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .axil_req_i  (axil_req),
        .axil_rsp_o  (axil_rsp),
        .in_valid_i  (in_valid_i),
        .bf_in_i     (bf_in_i),
        .out_valid_o (out_valid_o),
        .bf_out_o    (bf_out_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic longint unmask(input masked_coeff_t c);
        return (longint'(c.share0) + longint'(c.share1)) % longint'(Q);
    endfunction

    task automatic check_coeff(input masked_coeff_t got, input longint expected,
                               input string name);
        longint value;
        value = unmask(got);
        if (value != expected) begin
            $display("error time=%0t %s got=%0d expected=%0d", $time, name, value, expected);
            report_failure();
        end
    endtask

    task automatic check_word(input logic [AXI_DATA_W-1:0] got,
                              input logic [AXI_DATA_W-1:0] expected, input string name);
        if (got !== expected) begin
            $display("error time=%0t %s got=%0d expected=%0d", $time, name, got, expected);
            report_failure();
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] expected,
                              input string name);
        if (got !== expected) begin
            $display("error time=%0t %s got=%b expected=%b", $time, name, got, expected);
            report_failure();
        end
    endtask

    function automatic logic [COEFF_W-1:0] rand_below_q();
        logic [31:0] r;
        r = $random(seed);
        return COEFF_W'(r % 32'(Q));
    endfunction

    // share1 is chosen so that the two shares sum to x mod Q
    function automatic masked_coeff_t split_value(input logic [COEFF_W-1:0] x);
        masked_coeff_t c;
        c.share0 = rand_below_q();
        c.share1 = COEFF_W'((longint'(x) + longint'(Q) - longint'(c.share0)) % longint'(Q));
        return c;
    endfunction

    function automatic bf_in_t random_item();
        bf_in_t it;
        it.opu = split_value(rand_below_q());
        it.opv = split_value(rand_below_q());
        it.opw = split_value(rand_below_q());
        return it;
    endfunction

    // reference model, works on the unmasked values only
    task automatic observe_cycle();
        longint u;
        longint v;
        longint w;
        longint t;
        cycle = cycle + 1;
        if (out_valid_o) begin
            if (exp_u_q.size() == 0) begin
                $display("out_valid_o was raised at %0t with no butterfly in flight", $time);
                report_failure();
            end else begin
                t = in_time_q.pop_front();
                check_word(32'(cycle - t), 32'(BF_LATENCY), "out_valid_o latency");
                check_coeff(bf_out_o.u, exp_u_q.pop_front(), "bf_out_o.u");
                check_coeff(bf_out_o.v, exp_v_q.pop_front(), "bf_out_o.v");
                last_u = bf_out_o.u;
            end
        end
        if (in_valid_i) begin
            u = unmask(bf_in_i.opu);
            v = unmask(bf_in_i.opv);
            w = unmask(bf_in_i.opw);
            if (model_mode == gs) begin
                exp_u_q.push_back((u + v) % longint'(Q));
                exp_v_q.push_back((((u + longint'(Q) - v) % longint'(Q)) * w) % longint'(Q));
            end else begin
                exp_u_q.push_back(((u * v) % longint'(Q) + (model_acc ? w : 0)) % longint'(Q));
                exp_v_q.push_back(0);
            end
            in_time_q.push_back(cycle);
            in_sent = in_sent + 1;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset_n) begin
            observe_cycle();
        end
    end

    task automatic drive_item(input bf_in_t item);
        @(posedge clk);
        in_valid_i <= 1'b1;
        bf_in_i    <= item;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    task automatic send_random(input int n);
        repeat (n) drive_item(random_item());
        drive_idle();
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_u_q.size() != 0 && cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_u_q.size() != 0) begin
            $display("pipeline did not drain, %0d results never came out", exp_u_q.size());
            report_failure();
        end
    endtask

    // aw and w go out together, ready comes back in the same cycle
    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr,
                              input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        int cnt;
        cnt = 0;
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= '1;
        axil_req.wvalid  <= 1'b1;
        do begin
            @(negedge clk);
            cnt++;
        end while (!(axil_rsp.awready && axil_rsp.wready) && cnt < HANDSHAKE_LIMIT);
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            $display("register block never accepted the write to address 0x%0h", addr);
            report_failure();
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!axil_rsp.bvalid && cnt < HANDSHAKE_LIMIT);
        resp = axil_rsp.bresp;
        if (!axil_rsp.bvalid) begin
            $display("no write response from the register block for address 0x%0h", addr);
            report_failure();
        end
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr,
                             output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        int cnt;
        cnt = 0;
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        do begin
            @(negedge clk);
            cnt++;
        end while (!axil_rsp.arready && cnt < HANDSHAKE_LIMIT);
        if (!axil_rsp.arready) begin
            $display("register block never accepted the read of address 0x%0h", addr);
            report_failure();
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!axil_rsp.rvalid && cnt < HANDSHAKE_LIMIT);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        if (!axil_rsp.rvalid) begin
            $display("no read data from the register block for address 0x%0h", addr);
            report_failure();
        end
    endtask

    task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_resp(resp, AXI_RESP_OKAY, "bresp");
    endtask

    task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr,
                               input logic [AXI_DATA_W-1:0] expected);
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        axil_read(addr, data, resp);
        check_resp(resp, AXI_RESP_OKAY, "rresp");
        check_word(data, expected, $sformatf("rdata at 0x%0h", addr));
    endtask

    task automatic set_mode(input mode_t mode, input logic acc);
        write_reg(REG_CTRL, {30'd0, acc, (mode == pwm)});
        read_expect(REG_CTRL, {30'd0, acc, (mode == pwm)});
        model_mode = mode;
        model_acc  = acc;
    endtask

    initial begin
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        bf_in_t                item;
        masked_coeff_t         first_u;
        seed       = 59;
        reset_n    = 1'b0;
        axil_req   = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        in_valid_i = 1'b0;
        bf_in_i    = '0;
        model_mode = gs;
        model_acc  = 1'b0;
        cycle      = 0;
        in_sent    = 0;
        last_u     = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        read_expect(REG_CTRL, 32'd0);
        read_expect(REG_COUNT, 32'd0);

        // gs butterflies back to back
        send_random(200);
        drain();
        read_expect(REG_COUNT, 32'(in_sent));

        // pointwise multiply, then multiply-accumulate
        set_mode(pwm, 1'b0);
        send_random(100);
        drain();
        set_mode(pwm, 1'b1);
        send_random(100);
        drain();
        read_expect(REG_COUNT, 32'(in_sent));

        // unmapped offsets
        axil_write(4'h2, 32'hFFFF_FFFF, resp);
        check_resp(resp, AXI_RESP_SLVERR, "bresp of unmapped write");
        axil_read(4'h6, data, resp);
        check_resp(resp, AXI_RESP_SLVERR, "rresp of unmapped read");
        check_word(data, 32'd0, "rdata of unmapped read");
        read_expect(REG_CTRL, 32'd3);

        // same input under two seeds, the shares must move but not the value
        set_mode(gs, 1'b0);
        item = random_item();
        write_reg(REG_SEED, 32'h1234_5678);
        drive_item(item);
        drive_idle();
        drain();
        first_u = last_u;
        write_reg(REG_SEED, 32'h0BAD_F00D);
        drive_item(item);
        drive_idle();
        drain();
        if (last_u.share0 == first_u.share0) begin
            $display("share0 of bf_out_o.u did not change after the reseed");
            report_failure();
        end

        // zeroize with items in flight
        set_mode(pwm, 1'b1);
        send_random(8);
        write_reg(REG_ZEROIZE, 32'd1);
        @(posedge clk);
        exp_u_q.delete();
        exp_v_q.delete();
        in_time_q.delete();
        in_sent    = 0;
        model_mode = gs;
        model_acc  = 1'b0;
        repeat (12) @(posedge clk);
        read_expect(REG_COUNT, 32'd0);
        read_expect(REG_CTRL, 32'd0);

        // fresh work after the zeroize
        send_random(50);
        drain();
        read_expect(REG_COUNT, 32'(in_sent));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: list.f
common/masked_ntt_pkg.sv
rtl/share_delay.sv
rtl/masked_add_sub.sv
rtl/masked_mult.sv
rtl/mask_prng.sv
masked_butterfly/masked_gs_butterfly.sv
masked_butterfly/bf_ctrl_regs.sv
rtl/masked_bf_top.sv
verif/tb_masked_bf.sv

// File: Makefile
# Verilator build for the masked butterfly testbench
# every variable can be overridden from the command line

VERILATOR ?= verilator
TOP       ?= tb_masked_bf
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exits non-zero when the testbench hits $fatal
run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
